//--- logic/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

`define CPU_WORD_W    16
`define CPU_REG_N     8
`define CPU_UADDR_W   8
`define CPU_UDONE     8'd255
`define CPU_USKIP     8'd254
`define CPU_RESET_PC  16'h0000

// opcode numbers, ir[15:10]
`define CPU_OP_HALT   6'd0
`define CPU_OP_NOT    6'd4
`define CPU_OP_INC    6'd5
`define CPU_OP_DEC    6'd6
`define CPU_OP_AND    6'd7
`define CPU_OP_OR     6'd8
`define CPU_OP_XOR    6'd9
`define CPU_OP_ADD    6'd10
`define CPU_OP_SUB    6'd12
`define CPU_OP_CMP    6'd16
`define CPU_OP_JMP    6'd23
`define CPU_OP_JZ     6'd24
`define CPU_OP_JNZ    6'd25
`define CPU_OP_MOV    6'd32
`define CPU_OP_LD     6'd33
`define CPU_OP_LDI    6'd35
`define CPU_OP_ST     6'd37

`endif

//--- logic/cpu_pkg.sv
`include "cpu_cfg.svh"

package cpu_pkg;

    typedef logic [`CPU_WORD_W-1:0] word_t;

    typedef struct packed {
        logic [5:0] opcode;
        logic [2:0] rx;
        logic [2:0] ry;
        logic [3:0] unused;
    } instr_t;

    typedef enum logic [2:0] {
        BUS_NONE, BUS_REG, BUS_TEMP, BUS_SUM, BUS_RX, BUS_RY, BUS_MEM, BUS_PC
    } bus_src_e;

    typedef enum logic [3:0] {
        DST_NONE, DST_A, DST_B, DST_REG, DST_TEMP, DST_MAR,
        DST_PC, DST_SEL, DST_IR, DST_SUM, DST_MEM
    } reg_dst_e;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_NOT, ALU_INC, ALU_DEC, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR
    } alu_op_e;

    // count is pc+1, flag loads z from the alu result
    typedef enum logic [2:0] {
        FLOW_NONE, FLOW_COUNT, FLOW_DONE, FLOW_HALT, FLOW_FLAG
    } flow_e;

    typedef struct packed {
        logic [`CPU_UADDR_W-1:0] next_addr;
        flow_e                   flow;
        alu_op_e                 alu_op;
        reg_dst_e                reg_dst;
        bus_src_e                bus_src;
    } ctrl_word_t;

    typedef struct packed {
        word_t addr;
        logic  we;
        word_t wdata;
    } mem_req_t;

    function automatic ctrl_word_t cw(input logic [`CPU_UADDR_W-1:0] nxt, input flow_e fl,
                                      input alu_op_e op, input reg_dst_e dst,
                                      input bus_src_e src);
        return '{next_addr: nxt, flow: fl, alu_op: op, reg_dst: dst, bus_src: src};
    endfunction

    // routine entry for an opcode
    function automatic logic [`CPU_UADDR_W-1:0] op_addr(input logic [5:0] opcode);
        return {{(`CPU_UADDR_W-6){1'b0}}, opcode};
    endfunction

endpackage

//--- logic/alu.sv
`timescale 1ns/100ps

module alu
    import cpu_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  alu_op_e op,
    output word_t   result
);
    // all results wrap at 16 bits
    always_comb begin
        case (op)
            ALU_NOT: result = ~a;
            ALU_INC: result = a + word_t'(1);
            ALU_DEC: result = a - word_t'(1);
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            // nop passes a through
            default: result = a;
        endcase
    end

    always_comb begin
        assert final (op <= ALU_XOR)
            else $error("alu: op code %0d outside the kept set", op);
    end

endmodule

//--- logic/microcode_rom.sv
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module microcode_rom
    import cpu_pkg::*;
(
    input  logic [`CPU_UADDR_W-1:0] uaddr,
    output ctrl_word_t              uword
);
    // alu routines sit in 8-word slots: not inc dec and or xor add sub cmp
    localparam logic [`CPU_UADDR_W-1:0] ALU_BASE = 8'd64;
    localparam logic [`CPU_UADDR_W-1:0] ALU_END  = 8'd136;
    localparam logic [`CPU_UADDR_W-1:0] JMP_BODY = 8'd207;
    localparam logic [`CPU_UADDR_W-1:0] MOV_BODY = 8'd208;
    localparam logic [`CPU_UADDR_W-1:0] LD_BODY  = 8'd212;
    localparam logic [`CPU_UADDR_W-1:0] LDI_BODY = 8'd225;
    localparam logic [`CPU_UADDR_W-1:0] ST_BODY  = 8'd234;

    localparam ctrl_word_t DONE_WORD = cw(`CPU_UDONE, FLOW_DONE, ALU_NOP, DST_NONE, BUS_NONE);

    logic [`CPU_UADDR_W-1:0] alu_off;

    function automatic ctrl_word_t alu_entry(input logic [3:0] slot);
        return cw(ALU_BASE + {1'b0, slot, 3'b000}, FLOW_NONE, ALU_NOP, DST_SEL, BUS_RX);
    endfunction

    function automatic ctrl_word_t alu_step(input logic [3:0] slot, input logic [2:0] step);
        logic [`CPU_UADDR_W-1:0] base;
        logic                    unary;
        alu_op_e                 op;
        ctrl_word_t              w;
        base  = ALU_BASE + {1'b0, slot, 3'b000};
        unary = (slot < 4'd3);
        case (slot)
            4'd0:    op = ALU_NOT;
            4'd1:    op = ALU_INC;
            4'd2:    op = ALU_DEC;
            4'd3:    op = ALU_AND;
            4'd4:    op = ALU_OR;
            4'd5:    op = ALU_XOR;
            4'd6:    op = ALU_ADD;
            default: op = ALU_SUB;
        endcase
        case (step)
            3'd0: w = cw(unary ? base + 8'd3 : base + 8'd1, FLOW_NONE, ALU_NOP, DST_A, BUS_REG);
            3'd1: w = cw(base + 8'd2, FLOW_NONE, ALU_NOP, DST_SEL, BUS_RY);
            3'd2: w = cw(base + 8'd3, FLOW_NONE, ALU_NOP, DST_B, BUS_REG);
            // cmp keeps only the flag
            3'd3: w = cw(slot == 4'd8 ? `CPU_UDONE : (unary ? base + 8'd5 : base + 8'd4),
                         FLOW_FLAG, op, DST_SUM, BUS_NONE);
            3'd4: w = cw(base + 8'd5, FLOW_NONE, ALU_NOP, DST_SEL, BUS_RX);
            3'd5: w = cw(`CPU_UDONE, FLOW_NONE, ALU_NOP, DST_REG, BUS_SUM);
            default: w = DONE_WORD;
        endcase
        return w;
    endfunction

    assign alu_off = uaddr - ALU_BASE;

    always_comb begin
        case (uaddr)
            op_addr(`CPU_OP_HALT): uword = cw(`CPU_UDONE, FLOW_HALT, ALU_NOP, DST_NONE, BUS_NONE);
            op_addr(`CPU_OP_NOT):  uword = alu_entry(4'd0);
            op_addr(`CPU_OP_INC):  uword = alu_entry(4'd1);
            op_addr(`CPU_OP_DEC):  uword = alu_entry(4'd2);
            op_addr(`CPU_OP_AND):  uword = alu_entry(4'd3);
            op_addr(`CPU_OP_OR):   uword = alu_entry(4'd4);
            op_addr(`CPU_OP_XOR):  uword = alu_entry(4'd5);
            op_addr(`CPU_OP_ADD):  uword = alu_entry(4'd6);
            op_addr(`CPU_OP_SUB):  uword = alu_entry(4'd7);
            op_addr(`CPU_OP_CMP):  uword = alu_entry(4'd8);
            // all jumps share one body; not-taken ones never get here
            op_addr(`CPU_OP_JMP), op_addr(`CPU_OP_JZ), op_addr(`CPU_OP_JNZ):
                uword = cw(JMP_BODY, FLOW_NONE, ALU_NOP, DST_MAR, BUS_PC);
            JMP_BODY:      uword = cw(`CPU_UDONE, FLOW_NONE, ALU_NOP, DST_PC, BUS_MEM);
            // mov rx <- ry
            op_addr(`CPU_OP_MOV): uword = cw(MOV_BODY, FLOW_NONE, ALU_NOP, DST_SEL, BUS_RY);
            MOV_BODY:         uword = cw(MOV_BODY + 8'd1, FLOW_NONE, ALU_NOP, DST_TEMP, BUS_REG);
            MOV_BODY + 8'd1:  uword = cw(MOV_BODY + 8'd2, FLOW_NONE, ALU_NOP, DST_SEL, BUS_RX);
            MOV_BODY + 8'd2:  uword = cw(`CPU_UDONE, FLOW_NONE, ALU_NOP, DST_REG, BUS_TEMP);
            // ld rx <- mem[ry]
            op_addr(`CPU_OP_LD):  uword = cw(LD_BODY, FLOW_NONE, ALU_NOP, DST_SEL, BUS_RY);
            LD_BODY:          uword = cw(LD_BODY + 8'd1, FLOW_NONE, ALU_NOP, DST_MAR, BUS_REG);
            LD_BODY + 8'd1:   uword = cw(LD_BODY + 8'd2, FLOW_NONE, ALU_NOP, DST_SEL, BUS_RX);
            LD_BODY + 8'd2:   uword = cw(`CPU_UDONE, FLOW_NONE, ALU_NOP, DST_REG, BUS_MEM);
            // ldi rx <- next word
            op_addr(`CPU_OP_LDI): uword = cw(LDI_BODY, FLOW_NONE, ALU_NOP, DST_MAR, BUS_PC);
            LDI_BODY:         uword = cw(LDI_BODY + 8'd1, FLOW_COUNT, ALU_NOP, DST_TEMP, BUS_MEM);
            LDI_BODY + 8'd1:  uword = cw(LDI_BODY + 8'd2, FLOW_NONE, ALU_NOP, DST_SEL, BUS_RX);
            LDI_BODY + 8'd2:  uword = cw(`CPU_UDONE, FLOW_NONE, ALU_NOP, DST_REG, BUS_TEMP);
            // st mem[rx] <- ry
            op_addr(`CPU_OP_ST):  uword = cw(ST_BODY, FLOW_NONE, ALU_NOP, DST_SEL, BUS_RX);
            ST_BODY:          uword = cw(ST_BODY + 8'd1, FLOW_NONE, ALU_NOP, DST_MAR, BUS_REG);
            ST_BODY + 8'd1:   uword = cw(ST_BODY + 8'd2, FLOW_NONE, ALU_NOP, DST_SEL, BUS_RY);
            ST_BODY + 8'd2:   uword = cw(`CPU_UDONE, FLOW_NONE, ALU_NOP, DST_MEM, BUS_REG);
            `CPU_USKIP:       uword = cw(`CPU_UDONE, FLOW_COUNT, ALU_NOP, DST_NONE, BUS_NONE);
            default: begin
                if (uaddr >= ALU_BASE && uaddr < ALU_END)
                    uword = alu_step(alu_off[6:3], alu_off[2:0]);
                else
                    uword = DONE_WORD;
            end
        endcase
    end

endmodule

//--- logic/control_sequencer.sv
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module control_sequencer
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  instr_t     ir,
    input  logic       z_flag,
    output ctrl_word_t ctrl,
    output logic       halted
);
    typedef enum logic [2:0] {FETCH, FETCH1, EXECUTE, MICRO, HALT} state_e;

    state_e                  state;
    logic [`CPU_UADDR_W-1:0] micro_pc;
    logic [`CPU_UADDR_W-1:0] entry;
    logic                    skip;
    ctrl_word_t              uword;

    microcode_rom u_rom (
        .uaddr (micro_pc),
        .uword (uword)
    );

    // untaken conditional jump steps over its target word
    assign skip  = (ir.opcode == `CPU_OP_JZ && !z_flag) || (ir.opcode == `CPU_OP_JNZ && z_flag);
    assign entry = skip ? `CPU_USKIP : op_addr(ir.opcode);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= FETCH;
            micro_pc <= '0;
        end else begin
            case (state)
                FETCH:   state <= FETCH1;
                FETCH1:  state <= EXECUTE;
                EXECUTE: begin
                    micro_pc <= entry;
                    state    <= MICRO;
                end
                MICRO: begin
                    if (uword.flow == FLOW_HALT)
                        state <= HALT;
                    else if (uword.flow == FLOW_DONE || uword.next_addr == `CPU_UDONE)
                        state <= FETCH;
                    else
                        micro_pc <= uword.next_addr;
                end
                default: state <= HALT;
            endcase
        end
    end

    always_comb begin
        case (state)
            FETCH:   ctrl = cw(`CPU_UDONE, FLOW_NONE, ALU_NOP, DST_MAR, BUS_PC);
            FETCH1:  ctrl = cw(`CPU_UDONE, FLOW_COUNT, ALU_NOP, DST_IR, BUS_MEM);
            MICRO:   ctrl = uword;
            // execute and halt
            default: ctrl = cw(`CPU_UDONE, FLOW_NONE, ALU_NOP, DST_NONE, BUS_NONE);
        endcase
    end

    assign halted = (state == HALT);

    // a rom word never points back at its own step
    assert property (@(posedge clk) disable iff (reset)
        state == MICRO |-> uword.next_addr != micro_pc)
        else $error("sequencer: micro word loops on itself");

endmodule

//--- logic/datapath.sv
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module datapath
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  ctrl_word_t ctrl,
    input  word_t      mem_rdata,
    output word_t      bus,
    output instr_t     ir,
    output logic       z_flag
);
    localparam int SEL_W = $clog2(`CPU_REG_N);

    word_t            regs [`CPU_REG_N];
    logic [SEL_W-1:0] sel;
    word_t            a;
    word_t            b;
    word_t            temp;
    word_t            sum;
    word_t            pc;
    word_t            alu_result;

    alu u_alu (
        .a      (a),
        .b      (b),
        .op     (ctrl.alu_op),
        .result (alu_result)
    );

    // one source drives the shared bus per step
    always_comb begin
        case (ctrl.bus_src)
            BUS_REG:  bus = regs[sel];
            BUS_TEMP: bus = temp;
            BUS_SUM:  bus = sum;
            BUS_RX:   bus = word_t'(ir.rx);
            BUS_RY:   bus = word_t'(ir.ry);
            BUS_MEM:  bus = mem_rdata;
            BUS_PC:   bus = pc;
            default:  bus = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `CPU_REG_N; i++) begin
                regs[i] <= '0;
            end
            sel    <= '0;
            pc     <= `CPU_RESET_PC;
            ir     <= '0;
            z_flag <= 1'b0;
        end else begin
            case (ctrl.reg_dst)
                DST_REG: regs[sel] <= bus;
                // select latch addresses the file for read and write
                DST_SEL: sel <= bus[SEL_W-1:0];
                DST_IR:  ir <= instr_t'(bus);
                default: ;
            endcase
            if (ctrl.reg_dst == DST_PC)
                pc <= bus;
            else if (ctrl.flow == FLOW_COUNT)
                pc <= pc + word_t'(1);
            if (ctrl.flow == FLOW_FLAG)
                z_flag <= (alu_result == '0);
        end
    end

    always_ff @(posedge clk) begin
        case (ctrl.reg_dst)
            DST_A:    a <= bus;
            DST_B:    b <= bus;
            DST_TEMP: temp <= bus;
            DST_SUM:  sum <= alu_result;
            default:  ;
        endcase
    end

    // a flag step from the ROM always names a real operation
    assert property (@(posedge clk) disable iff (reset)
        ctrl.flow == FLOW_FLAG |-> ctrl.alu_op != ALU_NOP)
        else $error("datapath: flag update with alu nop");

endmodule

//--- logic/mem_port.sv
`timescale 1ns/100ps

module mem_port
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  ctrl_word_t ctrl,
    input  word_t      bus,
    output mem_req_t   mem_req
);
    word_t mar;
    word_t wdata;
    logic  we;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mar <= '0;
            we  <= 1'b0;
        end else begin
            if (ctrl.reg_dst == DST_MAR)
                mar <= bus;
            // write pulse lands the cycle after the step
            we <= (ctrl.reg_dst == DST_MEM);
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.reg_dst == DST_MEM)
            wdata <= bus;
    end

    assign mem_req = '{addr: mar, we: we, wdata: wdata};

    assert property (@(posedge clk) disable iff (reset) we |=> !we)
        else $error("mem_port: write strobe held two cycles");

endmodule

//--- logic/cpu_top.sv
`timescale 1ns/100ps

module cpu_top
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  word_t    mem_rdata,
    output mem_req_t mem_req,
    output logic     halted
);
    ctrl_word_t ctrl;
    instr_t     ir;
    logic       z_flag;
    word_t      bus;

    control_sequencer u_seq (
        .clk    (clk),
        .reset  (reset),
        .ir     (ir),
        .z_flag (z_flag),
        .ctrl   (ctrl),
        .halted (halted)
    );

    datapath u_dp (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .mem_rdata (mem_rdata),
        .bus       (bus),
        .ir        (ir),
        .z_flag    (z_flag)
    );

    mem_port u_mem (
        .clk     (clk),
        .reset   (reset),
        .ctrl    (ctrl),
        .bus     (bus),
        .mem_req (mem_req)
    );

endmodule

//--- tb/cpu_model.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

`include "cpu_cfg.svh"

logic [15:0] lfsr_state;
word_t       prog_len;
int          n_instr;
word_t       model_mem [0:65535];
word_t       exp_addr [$];
word_t       exp_data [$];
int          taken_n;
int          skipped_n;
int          exec_n;

// x^16 + x^14 + x^13 + x^11 + 1, one step per bit
function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        v = {v[14:0], fb};
    end
    return v;
endfunction

function automatic logic [5:0] binary_op(input logic [2:0] k);
    case (k)
        3'd0:    return `CPU_OP_AND;
        3'd1:    return `CPU_OP_OR;
        3'd2:    return `CPU_OP_XOR;
        3'd3:    return `CPU_OP_ADD;
        default: return `CPU_OP_SUB;
    endcase
endfunction

function automatic logic [5:0] unary_op(input logic [1:0] k);
    case (k)
        2'd0:    return `CPU_OP_NOT;
        2'd1:    return `CPU_OP_INC;
        default: return `CPU_OP_DEC;
    endcase
endfunction

function automatic logic [5:0] jump_op(input logic [1:0] k);
    case (k)
        2'd0:    return `CPU_OP_JMP;
        2'd1:    return `CPU_OP_JZ;
        default: return `CPU_OP_JNZ;
    endcase
endfunction

task automatic emit(input word_t w);
    mem[prog_len] = w;
    prog_len = prog_len + 16'd1;
endtask

task automatic emit_op(input logic [5:0] op, input logic [2:0] rx, input logic [2:0] ry);
    emit({op, rx, ry, 4'h0});
    n_instr++;
endtask

task automatic emit_ldi(input logic [2:0] rx, input word_t imm);
    emit_op(`CPU_OP_LDI, rx, 3'd0);
    emit(imm);
endtask

// r6 and r7 only ever hold data addresses
task automatic build_program();
    logic [2:0] kind;
    logic [2:0] rx;
    logic [2:0] ry;
    prog_len = '0;
    n_instr  = 0;
    emit_ldi(3'd6, 16'h8000);
    emit_ldi(3'd7, 16'h8001);
    for (int i = 0; i < 40; i++) begin
        kind = 3'(rand_bits(3));
        rx   = 3'(rand_bits(3) % 16'd6);
        ry   = 3'(rand_bits(3));
        case (kind)
            3'd0: emit_ldi(rx, rand_bits(16));
            3'd1: emit_op(binary_op(3'(rand_bits(3) % 16'd5)), rx, ry);
            3'd2: emit_op(unary_op(2'(rand_bits(2) % 16'd3)), rx, ry);
            3'd3: emit_op(`CPU_OP_CMP, rx, ry);
            3'd4: emit_op(`CPU_OP_MOV, rx, ry);
            3'd5: begin
                emit_ldi(3'd6, 16'h8000 | rand_bits(4));
                emit_op(`CPU_OP_ST, 3'd6, ry);
            end
            3'd6: begin
                emit_ldi(3'd7, 16'h8000 | rand_bits(4));
                emit_op(`CPU_OP_LD, rx, 3'd7);
            end
            default: begin
                // target skips the single store right after the target word
                emit_op(jump_op(2'(rand_bits(2) % 16'd3)), 3'd0, 3'd0);
                emit(prog_len + 16'd2);
                emit_op(`CPU_OP_ST, 3'd6, ry);
            end
        endcase
    end
    for (int i = 0; i < 8; i++) begin
        emit_ldi(3'd7, 16'h9000 + 16'(i));
        emit_op(`CPU_OP_ST, 3'd7, 3'(i));
    end
    emit_op(`CPU_OP_HALT, 3'd0, 3'd0);
endtask

task automatic run_model();
    word_t  r [8];
    word_t  pc;
    word_t  res;
    instr_t ins;
    logic   z;
    logic   wr;
    logic   run;
    for (int i = 0; i < 8; i++) begin
        r[i] = '0;
    end
    pc = '0;
    z = 1'b0;
    run = 1'b1;
    exec_n = 0;
    taken_n = 0;
    skipped_n = 0;
    while (run && exec_n < 10000) begin
        ins = instr_t'(model_mem[pc]);
        pc = pc + 16'd1;
        exec_n++;
        wr = 1'b0;
        res = '0;
        case (ins.opcode)
            `CPU_OP_HALT: run = 1'b0;
            `CPU_OP_NOT: begin res = ~r[ins.rx]; wr = 1'b1; end
            `CPU_OP_INC: begin res = r[ins.rx] + 16'd1; wr = 1'b1; end
            `CPU_OP_DEC: begin res = r[ins.rx] - 16'd1; wr = 1'b1; end
            `CPU_OP_AND: begin res = r[ins.rx] & r[ins.ry]; wr = 1'b1; end
            `CPU_OP_OR:  begin res = r[ins.rx] | r[ins.ry]; wr = 1'b1; end
            `CPU_OP_XOR: begin res = r[ins.rx] ^ r[ins.ry]; wr = 1'b1; end
            `CPU_OP_ADD: begin res = r[ins.rx] + r[ins.ry]; wr = 1'b1; end
            `CPU_OP_SUB: begin res = r[ins.rx] - r[ins.ry]; wr = 1'b1; end
            `CPU_OP_CMP: z = ((r[ins.rx] - r[ins.ry]) == 16'd0);
            `CPU_OP_JMP: begin pc = model_mem[pc]; taken_n++; end
            `CPU_OP_JZ, `CPU_OP_JNZ: begin
                if (z == (ins.opcode == `CPU_OP_JZ)) begin
                    pc = model_mem[pc];
                    taken_n++;
                end else begin
                    pc = pc + 16'd1;
                    skipped_n++;
                end
            end
            `CPU_OP_MOV: r[ins.rx] = r[ins.ry];
            `CPU_OP_LD:  r[ins.rx] = model_mem[r[ins.ry]];
            `CPU_OP_LDI: begin r[ins.rx] = model_mem[pc]; pc = pc + 16'd1; end
            `CPU_OP_ST: begin
                model_mem[r[ins.rx]] = r[ins.ry];
                exp_addr.push_back(r[ins.rx]);
                exp_data.push_back(r[ins.ry]);
            end
            default: ;
        endcase
        if (wr) begin
            r[ins.rx] = res;
            z = (res == 16'd0);
        end
    end
endtask

`endif

//--- tb/tb_cpu.sv
`timescale 1ns/100ps

module tb_cpu
    import cpu_pkg::*;
();
    logic     clk;
    logic     reset;
    word_t    mem_rdata;
    mem_req_t mem_req;
    logic     halted;
    word_t    mem [0:65535];
    int       errors;
    int       n_writes;

    `include "cpu_model.svh"

    cpu_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .halted    (halted)
    );

    always #2 clk = ~clk;

    // asynchronous read, write on the rising edge
    assign mem_rdata = mem[mem_req.addr];

    always @(posedge clk) begin
        if (mem_req.we)
            mem[mem_req.addr] <= mem_req.wdata;
    end

    task automatic check_idle();
        if (mem_req.we !== 1'b0) begin
            $display("[ERROR] mem_req.we got %h expected %h", mem_req.we, 1'b0);
            errors++;
        end
        if (halted !== 1'b0) begin
            $display("[ERROR] halted got %h expected %h", halted, 1'b0);
            errors++;
        end
    endtask

    task automatic check_write();
        word_t ea;
        word_t ed;
        n_writes++;
        if (exp_addr.size() == 0) begin
            $display("write to %h seen after all expected writes", mem_req.addr);
            errors++;
        end else begin
            ea = exp_addr.pop_front();
            ed = exp_data.pop_front();
            if (mem_req.addr !== ea) begin
                $display("[ERROR] mem_req.addr got %h expected %h", mem_req.addr, ea);
                errors++;
            end
            if (mem_req.wdata !== ed) begin
                $display("[ERROR] mem_req.wdata got %h expected %h", mem_req.wdata, ed);
                errors++;
            end
        end
    endtask

    initial begin
        word_t fill;
        int    e0;
        int    cycles;
        int    limit;
        int    exp_total;
        clk = 1'b0;
        reset = 1'b1;
        errors = 0;
        n_writes = 0;
        lfsr_state = 16'd58;
        for (int a = 0; a < 65536; a++) begin
            fill = word_t'(a);
            mem[a] = {fill[7:0], fill[15:8]} ^ 16'h5a3c;
        end
        build_program();
        model_mem = mem;
        run_model();
        exp_total = exp_addr.size();
        limit = n_instr * 10 + 50;

        e0 = errors;
        repeat (4) begin
            @(negedge clk);
            check_idle();
        end
        reset = 1'b0;
        @(negedge clk);
        check_idle();
        if (mem_req.addr !== 16'h0000) begin
            $display("[ERROR] mem_req.addr got %h expected %h", mem_req.addr, 16'h0000);
            errors++;
        end
        $display("test reset: %0d errors", errors - e0);

        e0 = errors;
        cycles = 0;
        while (!halted && cycles < limit) begin
            @(negedge clk);
            cycles++;
            if (mem_req.we)
                check_write();
        end
        $display("test writes: %0d seen, %0d jumps taken, %0d skipped, %0d errors",
                 n_writes, taken_n, skipped_n, errors - e0);

        e0 = errors;
        if (!halted) begin
            $display("halted did not rise within %0d cycles", limit);
            errors++;
        end else begin
            repeat (20) begin
                @(negedge clk);
                if (halted !== 1'b1) begin
                    $display("[ERROR] halted got %h expected %h", halted, 1'b1);
                    errors++;
                end
                if (mem_req.we) begin
                    $display("write seen after halt at address %h", mem_req.addr);
                    errors++;
                end
            end
            if (n_writes != exp_total) begin
                $display("[ERROR] write_count got %h expected %h", n_writes, exp_total);
                errors++;
            end
        end
        $display("test halt: %0d cycles, %0d errors", cycles, errors - e0);

        $display("summary: %0d instructions run, %0d writes, %0d errors",
                 exec_n, n_writes, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- files.f
+incdir+logic
+incdir+tb
logic/cpu_pkg.sv
logic/alu.sv
logic/microcode_rom.sv
logic/control_sequencer.sv
logic/datapath.sv
logic/mem_port.sv
logic/cpu_top.sv
tb/tb_cpu.sv

//--- run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cpu -f files.f -o tb_cpu
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF '*** PASSED ***' sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
